/* common/i2c_master_pkg.sv */
package i2c_master_pkg;

    // -------------------------------------------------------------------------
    // widths
    // -------------------------------------------------------------------------

    // width of the state register
    localparam int STATE_W = 4;

    // bit index and scl rise counter share this width
    localparam int BIT_CNT_W = 4;

    // bits per byte on the bus
    localparam int DEFAULT_DATA_BITS = 8;

    // -------------------------------------------------------------------------
    // bus states
    // -------------------------------------------------------------------------

    // encodings kept fixed so traces line up
    typedef enum logic [STATE_W-1:0] {
        // bus free, all line enables off
        ST_IDLE           = 4'b0000,
        // sda pulled low while scl high
        ST_START          = 4'b0001,
        // slave address plus r/w bit
        ST_ADDRESS        = 4'b0010,
        // ack from slave after the address
        ST_READ_ACK       = 4'b0011,
        // master sends a data byte
        ST_WRITE_DATA     = 4'b0100,
        // ack from slave after a data byte
        ST_READ_LATER_ACK = 4'b0101,
        // master samples a data byte
        ST_READ_DATA      = 4'b0110,
        // master acks (or nacks) a received byte
        ST_WRITE_ACK      = 4'b0111,
        // sda released ahead of a new start
        ST_REPEAT_START   = 4'b1000,
        // sda low then released while scl high
        ST_STOP           = 4'b1001
    } i2c_state_e;

endpackage

/* rtl/i2c_bit_tracker.sv */
`timescale 1ns/10ps

module i2c_bit_tracker
    import i2c_master_pkg::*;
#(
    parameter int DATA_BITS = DEFAULT_DATA_BITS
) (
    input  logic                 i2c_core_clk_i,
    input  logic                 reset_ni,
    input  logic                 i2c_scl_i,
    input  i2c_state_e           state_i,
    output logic                 scl_rise_o,
    output logic                 scl_fall_o,
    output logic                 byte_done_o,
    output logic [BIT_CNT_W-1:0] count_bit_o
);

    localparam logic [BIT_CNT_W-1:0] LAST_BIT   = BIT_CNT_W'(DATA_BITS - 1);
    localparam logic [BIT_CNT_W-1:0] BYTE_RISES = BIT_CNT_W'(DATA_BITS);

    logic                 scl_q;
    logic                 in_byte;
    logic                 tx_byte;
    logic [BIT_CNT_W-1:0] rise_cnt_q;
    logic [BIT_CNT_W-1:0] count_bit_q;

    // -------------------------------------------------------------------------
    // scl edge detection
    // -------------------------------------------------------------------------

    // idle bus is high, so no false rise out of reset
    always_ff @(posedge i2c_core_clk_i or negedge reset_ni) begin
        if (!reset_ni) begin
            scl_q <= 1'b1;
        end else begin
            scl_q <= i2c_scl_i;
        end
    end

    assign scl_rise_o = i2c_scl_i & ~scl_q;
    assign scl_fall_o = ~i2c_scl_i & scl_q;

    // -------------------------------------------------------------------------
    // rise counting per byte
    // -------------------------------------------------------------------------

    assign tx_byte = (state_i == ST_ADDRESS) || (state_i == ST_WRITE_DATA);
    assign in_byte = tx_byte || (state_i == ST_READ_DATA);

    always_ff @(posedge i2c_core_clk_i or negedge reset_ni) begin
        if (!reset_ni) begin
            rise_cnt_q <= '0;
        end else if (!in_byte) begin
            rise_cnt_q <= '0;
        end else if (scl_rise_o) begin
            rise_cnt_q <= rise_cnt_q + 1'b1;
        end
    end

    // last bit clocked in or out, wait for scl low before the ack bit
    assign byte_done_o = in_byte && scl_fall_o && (rise_cnt_q == BYTE_RISES);

    // -------------------------------------------------------------------------
    // bit index to the datapath
    // -------------------------------------------------------------------------

    always_ff @(posedge i2c_core_clk_i or negedge reset_ni) begin
        if (!reset_ni) begin
            count_bit_q <= LAST_BIT;
        end else if (tx_byte) begin
            // sending, next bit goes out once scl has gone high
            if (scl_rise_o && count_bit_q != '0) begin
                count_bit_q <= count_bit_q - 1'b1;
            end
        end else if (state_i == ST_READ_DATA) begin
            // receiving, step after the bit was sampled
            if (scl_fall_o && count_bit_q != '0) begin
                count_bit_q <= count_bit_q - 1'b1;
            end
        end else begin
            count_bit_q <= LAST_BIT;
        end
    end

    assign count_bit_o = count_bit_q;

    a_count_bit_range: assert property (
        @(posedge i2c_core_clk_i) disable iff (!reset_ni)
        count_bit_q <= LAST_BIT
    );

endmodule

/* i2c_master_fsm/i2c_state_ctrl.sv */
`timescale 1ns/10ps

module i2c_state_ctrl
    import i2c_master_pkg::*;
(
    input  logic       i2c_core_clk_i,
    input  logic       reset_ni,
    input  logic       enable_i,
    input  logic       repeat_start_i,
    input  logic       rw_i,
    input  logic       full_i,
    input  logic       empty_i,
    input  logic       i2c_sda_i,
    input  logic       scl_rise_i,
    input  logic       scl_fall_i,
    input  logic       byte_done_i,
    output i2c_state_e state_o,
    output logic       w_fifo_en_o,
    output logic       r_fifo_en_o,
    output logic       reset_done_o
);

    i2c_state_e state_q;
    i2c_state_e state_d;

    logic read_go_q;
    logic write_go_q;
    logic ack_sample;
    logic w_fifo_en_q;
    logic r_fifo_en_q;
    logic reset_done_q;

    // -------------------------------------------------------------------------
    // state register
    // -------------------------------------------------------------------------

    always_ff @(posedge i2c_core_clk_i or negedge reset_ni) begin
        if (!reset_ni) begin
            state_q      <= ST_IDLE;
            reset_done_q <= 1'b1;
        end else begin
            state_q      <= state_d;
            reset_done_q <= 1'b0;
        end
    end

    // -------------------------------------------------------------------------
    // next state
    // -------------------------------------------------------------------------

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (enable_i) begin
                    state_d = ST_START;
                end
            end
            // scl starts toggling, first low phase carries the address msb
            ST_START: begin
                if (scl_fall_i) begin
                    state_d = ST_ADDRESS;
                end
            end
            ST_ADDRESS: begin
                if (byte_done_i) begin
                    state_d = ST_READ_ACK;
                end
            end
            ST_READ_ACK: begin
                if (scl_fall_i) begin
                    if (read_go_q) begin
                        state_d = ST_READ_DATA;
                    end else if (write_go_q) begin
                        state_d = ST_WRITE_DATA;
                    end else begin
                        state_d = ST_STOP;
                    end
                end
            end
            ST_WRITE_DATA: begin
                if (byte_done_i) begin
                    state_d = ST_READ_LATER_ACK;
                end
            end
            ST_READ_LATER_ACK: begin
                if (scl_fall_i) begin
                    if (empty_i || (!write_go_q && !repeat_start_i)) begin
                        state_d = ST_STOP;
                    end else if (write_go_q) begin
                        state_d = ST_WRITE_DATA;
                    end else begin
                        state_d = ST_REPEAT_START;
                    end
                end
            end
            ST_READ_DATA: begin
                if (byte_done_i) begin
                    state_d = ST_WRITE_ACK;
                end
            end
            ST_WRITE_ACK: begin
                if (scl_fall_i) begin
                    if (repeat_start_i) begin
                        state_d = ST_REPEAT_START;
                    end else if (!full_i) begin
                        state_d = ST_READ_DATA;
                    end else begin
                        state_d = ST_STOP;
                    end
                end
            end
            ST_REPEAT_START: begin
                if (scl_rise_i) begin
                    state_d = ST_START;
                end
            end
            ST_STOP: begin
                if (scl_rise_i) begin
                    state_d = ST_IDLE;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    // -------------------------------------------------------------------------
    // ack flags and fifo strobes
    // -------------------------------------------------------------------------

    // ack bit is valid on the scl rise, sda low means ack
    assign ack_sample = scl_rise_i && !i2c_sda_i;

    always_ff @(posedge i2c_core_clk_i or negedge reset_ni) begin
        if (!reset_ni) begin
            read_go_q   <= 1'b0;
            write_go_q  <= 1'b0;
            r_fifo_en_q <= 1'b0;
            w_fifo_en_q <= 1'b0;
        end else begin
            if (state_q == ST_READ_ACK || state_q == ST_READ_LATER_ACK) begin
                if (ack_sample && rw_i && !full_i) begin
                    read_go_q  <= 1'b1;
                    write_go_q <= 1'b0;
                end else if (ack_sample && !rw_i && !empty_i) begin
                    read_go_q  <= 1'b0;
                    write_go_q <= 1'b1;
                end
            end else begin
                read_go_q  <= 1'b0;
                write_go_q <= 1'b0;
            end

            // pop the byte the slave just took
            r_fifo_en_q <= (state_q == ST_READ_LATER_ACK) && ack_sample;
            // push the received byte once
            w_fifo_en_q <= (state_q == ST_READ_DATA) && byte_done_i;
        end
    end

    assign state_o      = state_q;
    assign r_fifo_en_o  = r_fifo_en_q;
    assign w_fifo_en_o  = w_fifo_en_q;
    assign reset_done_o = reset_done_q;

    a_go_flags_exclusive: assert property (
        @(posedge i2c_core_clk_i) disable iff (!reset_ni)
        !(read_go_q && write_go_q)
    );

    a_fifo_strobes_exclusive: assert property (
        @(posedge i2c_core_clk_i) disable iff (!reset_ni)
        !(r_fifo_en_q && w_fifo_en_q)
    );

endmodule

/* i2c_master_fsm/i2c_line_ctrl.sv */
`timescale 1ns/10ps

module i2c_line_ctrl
    import i2c_master_pkg::*;
(
    input  i2c_state_e state_i,
    input  logic       i2c_scl_i,
    input  logic       i2c_sda_i,
    input  logic       full_i,
    output logic       clk_en_o,
    output logic       sda_low_en_o,
    output logic       write_addr_en_o,
    output logic       write_data_en_o,
    output logic       receive_data_en_o,
    output logic       i2c_sda_en_o,
    output logic       i2c_scl_en_o,
    output logic       start_done_o
);

    // -------------------------------------------------------------------------
    // per-state line decode
    // -------------------------------------------------------------------------

    always_comb begin
        clk_en_o          = 1'b0;
        sda_low_en_o      = 1'b0;
        write_addr_en_o   = 1'b0;
        write_data_en_o   = 1'b0;
        receive_data_en_o = 1'b0;
        i2c_sda_en_o      = 1'b0;
        i2c_scl_en_o      = 1'b0;

        case (state_i)
            ST_START: begin
                clk_en_o     = 1'b1;
                sda_low_en_o = 1'b1;
                i2c_sda_en_o = 1'b1;
                i2c_scl_en_o = 1'b1;
            end
            // sda may only change while scl is low
            ST_ADDRESS: begin
                clk_en_o        = 1'b1;
                write_addr_en_o = ~i2c_scl_i;
                i2c_sda_en_o    = 1'b1;
                i2c_scl_en_o    = 1'b1;
            end
            ST_READ_ACK: begin
                clk_en_o     = 1'b1;
                i2c_scl_en_o = 1'b1;
            end
            ST_WRITE_DATA: begin
                clk_en_o        = 1'b1;
                write_data_en_o = ~i2c_scl_i;
                i2c_sda_en_o    = 1'b1;
                i2c_scl_en_o    = 1'b1;
            end
            // sda released, slave drives the ack
            ST_READ_LATER_ACK: begin
                clk_en_o     = 1'b1;
                sda_low_en_o = 1'b1;
                i2c_scl_en_o = 1'b1;
            end
            // sample while data is stable
            ST_READ_DATA: begin
                clk_en_o          = 1'b1;
                receive_data_en_o = i2c_scl_i;
                i2c_scl_en_o      = 1'b1;
            end
            // full fifo leaves sda released, which reads as nack
            ST_WRITE_ACK: begin
                clk_en_o     = 1'b1;
                sda_low_en_o = 1'b1;
                i2c_sda_en_o = ~full_i;
                i2c_scl_en_o = 1'b1;
            end
            // let sda float high before the next start
            ST_REPEAT_START: begin
                clk_en_o     = 1'b1;
                i2c_scl_en_o = 1'b1;
            end
            // pull sda low first, then release it while scl is high
            ST_STOP: begin
                clk_en_o     = 1'b1;
                sda_low_en_o = i2c_sda_i;
                i2c_sda_en_o = 1'b1;
                i2c_scl_en_o = 1'b1;
            end
            default: begin
                clk_en_o = 1'b0;
            end
        endcase
    end

    assign start_done_o = (state_i != ST_IDLE);

endmodule

/* rtl/i2c_master_fsm.sv */
`timescale 1ns/10ps

module i2c_master_fsm
    import i2c_master_pkg::*;
#(
    parameter int DATA_BITS = DEFAULT_DATA_BITS
) (
    input  logic                 enable_i,
    input  logic                 reset_ni,
    input  logic                 repeat_start_i,
    input  logic                 rw_i,
    input  logic                 full_i,
    input  logic                 empty_i,
    input  logic                 i2c_core_clk_i,
    input  logic                 i2c_sda_i,
    input  logic                 i2c_scl_i,
    output logic                 w_fifo_en_o,
    output logic                 r_fifo_en_o,
    output logic                 sda_low_en_o,
    output logic                 clk_en_o,
    output logic                 write_data_en_o,
    output logic                 write_addr_en_o,
    output logic                 receive_data_en_o,
    output logic [BIT_CNT_W-1:0] count_bit_o,
    output logic                 i2c_sda_en_o,
    output logic                 i2c_scl_en_o,
    output logic                 start_done_o,
    output logic                 reset_done_o
);

    i2c_state_e state;
    logic       scl_rise;
    logic       scl_fall;
    logic       byte_done;

    // -------------------------------------------------------------------------
    // scl events and bit index
    // -------------------------------------------------------------------------

    i2c_bit_tracker #(
        .DATA_BITS (DATA_BITS)
    ) u_bit_tracker (
        .i2c_core_clk_i (i2c_core_clk_i),
        .reset_ni       (reset_ni),
        .i2c_scl_i      (i2c_scl_i),
        .state_i        (state),
        .scl_rise_o     (scl_rise),
        .scl_fall_o     (scl_fall),
        .byte_done_o    (byte_done),
        .count_bit_o    (count_bit_o)
    );

    // -------------------------------------------------------------------------
    // bus sequencing
    // -------------------------------------------------------------------------

    i2c_state_ctrl u_state_ctrl (
        .i2c_core_clk_i (i2c_core_clk_i),
        .reset_ni       (reset_ni),
        .enable_i       (enable_i),
        .repeat_start_i (repeat_start_i),
        .rw_i           (rw_i),
        .full_i         (full_i),
        .empty_i        (empty_i),
        .i2c_sda_i      (i2c_sda_i),
        .scl_rise_i     (scl_rise),
        .scl_fall_i     (scl_fall),
        .byte_done_i    (byte_done),
        .state_o        (state),
        .w_fifo_en_o    (w_fifo_en_o),
        .r_fifo_en_o    (r_fifo_en_o),
        .reset_done_o   (reset_done_o)
    );

    // line and datapath enables
    i2c_line_ctrl u_line_ctrl (
        .state_i           (state),
        .i2c_scl_i         (i2c_scl_i),
        .i2c_sda_i         (i2c_sda_i),
        .full_i            (full_i),
        .clk_en_o          (clk_en_o),
        .sda_low_en_o      (sda_low_en_o),
        .write_addr_en_o   (write_addr_en_o),
        .write_data_en_o   (write_data_en_o),
        .receive_data_en_o (receive_data_en_o),
        .i2c_sda_en_o      (i2c_sda_en_o),
        .i2c_scl_en_o      (i2c_scl_en_o),
        .start_done_o      (start_done_o)
    );

endmodule

/* verif/tb_clk_gen.sv */
`timescale 1ns/10ps

module tb_clk_gen #(
    parameter time PERIOD     = 40ns,
    parameter int  RST_CYCLES = 8
) (
    output logic clk_o,
    output logic rst_no
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

    // short high phase first so the reset edge is seen by the flops
    initial begin
        rst_no = 1'b1;
        #5ns rst_no = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        rst_no <= 1'b1;
    end

endmodule

/* verif/tb_i2c_master_fsm.sv */
`timescale 1ns/10ps

module tb_i2c_master_fsm;

    localparam int SCL_HALF = 4;
    localparam int TIMEOUT  = 4000;
    localparam int SEL_RST  = 0;
    localparam int SEL_BUSY = 1;
    localparam int SEL_WDAT = 2;
    localparam int SEL_SCL  = 3;
    localparam int SEL_WPUL = 4;
    localparam int SEL_SLOW = 5;
    localparam int SEL_RPUL = 6;

    logic clk;
    logic rst_n;
    logic enable = 1'b0;
    logic repeat_start = 1'b0;
    logic rw = 1'b0;
    logic full = 1'b0;
    logic empty = 1'b0;
    logic scl = 1'b1;
    logic sda = 1'b1;
    logic w_fifo_en;
    logic r_fifo_en;
    logic sda_low_en;
    logic clk_en;
    logic write_data_en;
    logic write_addr_en;
    logic receive_data_en;
    logic sda_en;
    logic scl_en;
    logic start_done;
    logic reset_done;
    logic [3:0] count_bit;

    integer seed = 32'h190fa98f;
    int     scl_div = 0;
    logic   rx_bit = 1'b0;
    logic   ack_low = 1'b1;
    int     empty_after = 1000;
    int     full_after = 1000;
    int     r_count = 0;
    int     w_count = 0;
    logic   saw_wdat = 1'b0;
    logic   saw_rx = 1'b0;
    logic   saw_idle = 1'b0;
    int     errors = 0;
    int     test_errors = 0;
    int     tests = 0;
    int     failed = 0;
    int     n;

    tb_clk_gen u_clk_gen (.clk_o(clk), .rst_no(rst_n));

    i2c_master_fsm #(.DATA_BITS(8)) DUT (
        .enable_i(enable), .reset_ni(rst_n), .repeat_start_i(repeat_start), .rw_i(rw),
        .full_i(full), .empty_i(empty), .i2c_core_clk_i(clk), .i2c_sda_i(sda),
        .i2c_scl_i(scl), .w_fifo_en_o(w_fifo_en), .r_fifo_en_o(r_fifo_en),
        .sda_low_en_o(sda_low_en), .clk_en_o(clk_en), .write_data_en_o(write_data_en),
        .write_addr_en_o(write_addr_en), .receive_data_en_o(receive_data_en),
        .count_bit_o(count_bit), .i2c_sda_en_o(sda_en), .i2c_scl_en_o(scl_en),
        .start_done_o(start_done), .reset_done_o(reset_done)
    );

    // ------------------------------------------------------------------------
    // bus model with scl divider, open-drain sda, slave answers and fifo levels
    // ------------------------------------------------------------------------
    always @(posedge clk) begin
        if (!clk_en) begin
            scl <= 1'b1;
            scl_div <= 0;
        end else if (scl_div == SCL_HALF - 1) begin
            scl <= ~scl;
            scl_div <= 0;
            // new read bit on each rising scl
            if (!scl) begin
                rx_bit <= $random(seed);
            end
        end else begin
            scl_div <= scl_div + 1;
        end
        sda <= !((sda_en && sda_low_en) ||
                 (clk_en && !sda_en && (receive_data_en ? rx_bit : ack_low)));
        empty <= (r_count >= empty_after);
        full <= (w_count >= full_after);
    end

    // pulse counting and state flags
    always @(negedge clk) begin
        if (r_fifo_en) r_count = r_count + 1;
        if (w_fifo_en) w_count = w_count + 1;
        if (write_data_en) saw_wdat = 1'b1;
        if (receive_data_en) saw_rx = 1'b1;
        if (!start_done) saw_idle = 1'b1;
    end

    function automatic logic probe(input int sel);
        case (sel)
            SEL_RST:  return rst_n;
            SEL_BUSY: return start_done;
            SEL_WDAT: return write_data_en;
            SEL_SCL:  return scl;
            SEL_WPUL: return w_fifo_en;
            SEL_RPUL: return r_fifo_en;
            default:  return sda_low_en;
        endcase
    endfunction

    task automatic wait_level(input int sel, input logic level, input string what);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (probe(sel) !== level && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (probe(sel) !== level) begin
            $display("timeout while waiting for %s", what);
            errors++;
            test_errors++;
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    task automatic check_idle();
        check_value("clk_en_o", clk_en, 0);
        check_value("sda_low_en_o", sda_low_en, 0);
        check_value("write_addr_en_o", write_addr_en, 0);
        check_value("write_data_en_o", write_data_en, 0);
        check_value("receive_data_en_o", receive_data_en, 0);
        check_value("i2c_sda_en_o", sda_en, 0);
        check_value("i2c_scl_en_o", scl_en, 0);
        check_value("w_fifo_en_o", w_fifo_en, 0);
        check_value("r_fifo_en_o", r_fifo_en, 0);
        check_value("start_done_o", start_done, 0);
        check_value("count_bit_o", count_bit, 7);
    endtask

    task automatic start_transfer(input logic dir, input int e_after, input int f_after);
        r_count = 0;
        w_count = 0;
        saw_wdat = 1'b0;
        saw_rx = 1'b0;
        empty_after = e_after;
        full_after = f_after;
        repeat (2) @(posedge clk);
        rw <= dir;
        enable <= 1'b1;
        @(posedge clk);
        enable <= 1'b0;
        wait_level(SEL_BUSY, 1'b1, "start_done_o high");
        saw_idle = 1'b0;
    endtask

    task automatic finish_test(input string name);
        tests++;
        if (test_errors != 0) failed++;
        $display("test %s: %s (%0d errors)", name, test_errors == 0 ? "pass" : "fail",
                 test_errors);
        test_errors = 0;
    endtask

    initial begin
        // reset
        repeat (2) @(negedge clk);
        check_value("reset_done_o", reset_done, 1);
        wait_level(SEL_RST, 1'b1, "reset release");
        @(negedge clk);
        check_value("reset_done_o", reset_done, 0);
        check_idle();
        finish_test("reset");

        // write until empty after n acked bytes
        ack_low = 1'b1;
        n = ($unsigned($random(seed)) % 3) + 1;
        start_transfer(1'b0, n, 1000);
        for (int b = 0; b < n; b++) begin
            // skip to the ack of the previous byte
            if (b != 0) begin
                wait_level(SEL_RPUL, 1'b1, "r_fifo_en_o pulse");
            end
            for (int k = 0; k < 8; k++) begin
                wait_level(SEL_WDAT, 1'b1, "write_data_en_o high");
                check_value("count_bit_o", count_bit, 7 - k);
                wait_level(SEL_SCL, 1'b1, "scl high");
            end
        end
        wait_level(SEL_BUSY, 1'b0, "idle after write");
        check_idle();
        check_value("r_fifo_en_o pulses", r_count, n);
        check_value("w_fifo_en_o pulses", w_count, 0);
        check_value("write_data_en_o seen", saw_wdat, 1);
        finish_test("write");

        // address nack with a random direction
        ack_low = 1'b0;
        start_transfer($random(seed), 1000, 1000);
        wait_level(SEL_BUSY, 1'b0, "idle after address nack");
        check_idle();
        check_value("write_data_en_o seen", saw_wdat, 0);
        check_value("receive_data_en_o seen", saw_rx, 0);
        check_value("r_fifo_en_o pulses", r_count, 0);
        check_value("w_fifo_en_o pulses", w_count, 0);
        finish_test("address_nack");

        // read until full at the master ack
        ack_low = 1'b1;
        n = ($unsigned($random(seed)) % 3) + 1;
        start_transfer(1'b1, 1000, n);
        for (int k = 0; k < n; k++) begin
            wait_level(SEL_WPUL, 1'b1, "w_fifo_en_o pulse");
        end
        wait_level(SEL_SCL, 1'b1, "scl high in last ack bit");
        check_value("i2c_sda_en_o", sda_en, 0);
        wait_level(SEL_BUSY, 1'b0, "idle after read");
        check_idle();
        check_value("w_fifo_en_o pulses", w_count, n);
        check_value("r_fifo_en_o pulses", r_count, 0);
        check_value("receive_data_en_o seen", saw_rx, 1);
        finish_test("read");

        // repeated start after the first read byte
        @(posedge clk);
        repeat_start <= 1'b1;
        start_transfer(1'b1, 1000, 1);
        wait_level(SEL_WPUL, 1'b1, "first w_fifo_en_o pulse");
        wait_level(SEL_SLOW, 1'b0, "sda released for repeat start");
        wait_level(SEL_SLOW, 1'b1, "second start");
        check_value("start_done_o", start_done, 1);
        check_value("idle seen before second start", saw_idle, 0);
        @(posedge clk);
        repeat_start <= 1'b0;
        wait_level(SEL_BUSY, 1'b0, "idle after repeated start");
        check_idle();
        check_value("w_fifo_en_o pulses", w_count, 1);
        finish_test("repeat_start");

        $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* all.f */
common/i2c_master_pkg.sv
rtl/i2c_bit_tracker.sv
i2c_master_fsm/i2c_state_ctrl.sv
i2c_master_fsm/i2c_line_ctrl.sv
rtl/i2c_master_fsm.sv
verif/tb_clk_gen.sv
verif/tb_i2c_master_fsm.sv

/* Bender.yml */
package:
  name: i2c_master_fsm

sources:
  - common/i2c_master_pkg.sv
  - rtl/i2c_bit_tracker.sv
  - i2c_master_fsm/i2c_state_ctrl.sv
  - i2c_master_fsm/i2c_line_ctrl.sv
  - rtl/i2c_master_fsm.sv
  - target: simulation
    files:
      - verif/tb_clk_gen.sv
      - verif/tb_i2c_master_fsm.sv
